/* rtl/commit_defs.svh */
/* opcodes and machine CSR addresses for the commit slice; only the six CSRs listed here exist,
   every other address reads zero and drops its write */
`ifndef COMMIT_DEFS_SVH
`define COMMIT_DEFS_SVH

// simulation trap and CSR opcodes
`define TRAP_OPCODE   7'h6b
`define SYSTEM_OPCODE 7'h73

// machine mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

`define SSTATUS_MASK  64'h80000003_000de122  // sstatus bits visible in mstatus

`define CNT_W         64                     // cycle and instret width

`endif

/* rtl/commit_pkg.sv */
/* retire and commit record types; inst_u decodes one word as R-form or I-form,
   only the fields the commit slice uses are named */
`default_nettype none

package commit_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm12;  // CSR address for system ops
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef struct packed {
    logic [63:0] pc;
    inst_u       inst;
    logic        rd_wen;
    logic [63:0] rd_wdata;
    logic        skip;
  } retire_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    inst_u       inst;
    logic        wen;
    logic [7:0]  wdest;  // zero extended rd
    logic [63:0] wdata;
    logic        skip;
  } commit_t;

  typedef struct packed {
    logic [63:0] mstatus;
    logic [63:0] mie;
    logic [63:0] mtvec;
    logic [63:0] mscratch;
    logic [63:0] mepc;
    logic [63:0] mcause;
  } csr_state_t;

endpackage

`default_nettype wire

/* rtl/arch_regfile.sv */
/* 32 x 64 integer registers, x0 never written; combinational read,
   x10 (a0) brought out separately for the trap code */
`default_nettype none

module arch_regfile (
  input  wire        clk,
  input  wire        rst,
  input  wire        i_we,
  input  wire [4:0]  i_waddr,
  input  wire [63:0] i_wdata,
  input  wire [4:0]  i_raddr,
  output wire [63:0] o_rdata,
  output wire [63:0] o_a0
);

  logic [63:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != 5'd0)) begin  // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata = regs[i_raddr];
  assign o_a0    = regs[10];  // a0

endmodule

`default_nettype wire

/* rtl/csr_file.sv */
/* machine CSRs with CSRRW/CSRRS/CSRRC only (no immediate forms); unknown addresses
   read zero and ignore writes but still hit; interrupt capture wins over a CSR write */
`default_nettype none

`include "commit_defs.svh"

module csr_file (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_retire_ok,
  input  wire                     i_take_intr,
  input  commit_pkg::inst_u       i_inst,
  input  wire [63:0]              i_pc,
  input  wire [31:0]              i_intr_no,
  input  wire [63:0]              i_rs1_data,
  output wire                     o_csr_hit,
  output wire [63:0]              o_csr_rdata,
  output commit_pkg::csr_state_t  o_csr,
  output wire [63:0]              o_sstatus
);

  import commit_pkg::*;

  csr_state_t  csr_q;
  logic [11:0] addr;
  logic [2:0]  funct3;
  logic        is_csr_op;
  logic [63:0] old_val;
  logic [63:0] new_val;

  assign addr   = i_inst.i.imm12;
  assign funct3 = i_inst.i.funct3;

  // csrrw / csrrs / csrrc
  assign is_csr_op = (i_inst.i.opcode == `SYSTEM_OPCODE) &&
                     (funct3 == 3'd1 || funct3 == 3'd2 || funct3 == 3'd3);
  assign o_csr_hit = i_retire_ok && is_csr_op;

  always_comb begin
    case (addr)
      `CSR_MSTATUS:  old_val = csr_q.mstatus;
      `CSR_MIE:      old_val = csr_q.mie;
      `CSR_MTVEC:    old_val = csr_q.mtvec;
      `CSR_MSCRATCH: old_val = csr_q.mscratch;
      `CSR_MEPC:     old_val = csr_q.mepc;
      `CSR_MCAUSE:   old_val = csr_q.mcause;
      default:       old_val = '0;  // unimplemented
    endcase
  end

  always_comb begin
    case (funct3[1:0])
      2'b01:   new_val = i_rs1_data;              // write
      2'b10:   new_val = old_val | i_rs1_data;    // set
      default: new_val = old_val & ~i_rs1_data;   // clear
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      csr_q <= '0;
    end else if (i_take_intr) begin
      csr_q.mepc   <= i_pc;
      csr_q.mcause <= {1'b1, 31'd0, i_intr_no};  // interrupt bit on top
    end else if (o_csr_hit) begin
      case (addr)
        `CSR_MSTATUS:  csr_q.mstatus  <= new_val;
        `CSR_MIE:      csr_q.mie      <= new_val;
        `CSR_MTVEC:    csr_q.mtvec    <= new_val;
        `CSR_MSCRATCH: csr_q.mscratch <= new_val;
        `CSR_MEPC:     csr_q.mepc     <= new_val;
        `CSR_MCAUSE:   csr_q.mcause   <= new_val;
        default: ;
      endcase
    end
  end

  assign o_csr_rdata = old_val;
  assign o_csr       = csr_q;
  assign o_sstatus   = csr_q.mstatus & `SSTATUS_MASK;

endmodule

`default_nettype wire

/* rtl/commit_unit.sv */
/* one retire per cycle, no back-pressure; a CSR hit always writes rd with the old value.
   after the trap retire all state freezes until reset, valid drops one cycle later */
`default_nettype none

`include "commit_defs.svh"

module commit_unit (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_retire,
  input  commit_pkg::retire_t   i_ret,
  input  wire [31:0]            i_intr_no,
  input  wire                   i_csr_hit,
  input  wire [63:0]            i_csr_rdata,
  input  wire [63:0]            i_a0,
  output wire                   o_retire_ok,
  output wire                   o_take_intr,
  output wire                   o_rf_we,
  output wire [4:0]             o_rf_waddr,
  output wire [63:0]            o_rf_wdata,
  output commit_pkg::commit_t   o_commit,
  output wire                   o_trap,
  output wire [2:0]             o_trap_code,
  output wire [`CNT_W-1:0]      o_cycle_cnt,
  output wire [`CNT_W-1:0]      o_instr_cnt
);

  import commit_pkg::*;

  commit_t           cmt_q;
  logic              halt_q;
  logic [2:0]        code_q;
  logic [`CNT_W-1:0] cycle_q;
  logic [`CNT_W-1:0] instr_q;
  logic              intr_pend;
  logic              is_trap;
  logic [4:0]        rd;
  logic              wen;
  logic [63:0]       wdata;

  assign intr_pend = (i_intr_no != 32'd0);
  assign is_trap   = (i_ret.inst.r.opcode == `TRAP_OPCODE);
  assign rd        = i_ret.inst.r.rd;

  assign o_retire_ok = i_retire && !intr_pend && !halt_q;
  assign o_take_intr = i_retire && intr_pend && !halt_q;

  assign wen   = i_ret.rd_wen || i_csr_hit;
  assign wdata = i_csr_hit ? i_csr_rdata : i_ret.rd_wdata;  // csr old value

  assign o_rf_we    = o_retire_ok && wen && (rd != 5'd0);
  assign o_rf_waddr = rd;
  assign o_rf_wdata = wdata;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      cmt_q.valid <= 1'b0;
      halt_q      <= 1'b0;
      code_q      <= '0;
      cycle_q     <= '0;
      instr_q     <= '0;
    end else begin
      cmt_q.valid <= o_retire_ok;  // falls by itself once halted
      if (!halt_q) begin
        cycle_q <= cycle_q + 1'b1;
        if (o_retire_ok) begin
          instr_q <= instr_q + 1'b1;
        end
        if (o_retire_ok && is_trap) begin
          halt_q <= 1'b1;
          code_q <= i_a0[2:0];  // a0 before this edge
        end
      end
    end
  end

  // record payload
  always_ff @(posedge clk) begin
    if (!halt_q) begin
      cmt_q.pc    <= i_ret.pc;
      cmt_q.inst  <= i_ret.inst;
      cmt_q.wen   <= wen;
      cmt_q.wdest <= {3'd0, rd};
      cmt_q.wdata <= wdata;
      cmt_q.skip  <= i_ret.skip;
    end
  end

  assign o_commit    = cmt_q;
  assign o_trap      = halt_q;
  assign o_trap_code = code_q;
  assign o_cycle_cnt = cycle_q;
  assign o_instr_cnt = instr_q;

endmodule

`default_nettype wire

/* rtl/retire_top.sv */
/* retire-and-commit slice; i_ret is only looked at while i_retire is high,
   a nonzero i_intr_no turns that retire into an interrupt */
`default_nettype none

`include "commit_defs.svh"

module retire_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_retire,
  input  commit_pkg::retire_t     i_ret,
  input  wire [31:0]              i_intr_no,
  output commit_pkg::commit_t     o_commit,
  output commit_pkg::csr_state_t  o_csr,
  output wire [63:0]              o_sstatus,
  output wire                     o_trap,
  output wire [2:0]               o_trap_code,
  output wire [`CNT_W-1:0]        o_cycle_cnt,
  output wire [`CNT_W-1:0]        o_instr_cnt
);

  wire        retire_ok;
  wire        take_intr;
  wire        csr_hit;
  wire [63:0] csr_rdata;
  wire [63:0] rs1_data;
  wire [63:0] a0;
  wire        rf_we;
  wire [4:0]  rf_waddr;
  wire [63:0] rf_wdata;

  arch_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .i_we     (rf_we),
    .i_waddr  (rf_waddr),
    .i_wdata  (rf_wdata),
    .i_raddr  (i_ret.inst.i.rs1),
    .o_rdata  (rs1_data),
    .o_a0     (a0)
  );

  csr_file u_csr (
    .clk          (clk),
    .rst          (rst),
    .i_retire_ok  (retire_ok),
    .i_take_intr  (take_intr),
    .i_inst       (i_ret.inst),
    .i_pc         (i_ret.pc),
    .i_intr_no    (i_intr_no),
    .i_rs1_data   (rs1_data),
    .o_csr_hit    (csr_hit),
    .o_csr_rdata  (csr_rdata),
    .o_csr        (o_csr),
    .o_sstatus    (o_sstatus)
  );

  commit_unit u_commit (
    .clk          (clk),
    .rst          (rst),
    .i_retire     (i_retire),
    .i_ret        (i_ret),
    .i_intr_no    (i_intr_no),
    .i_csr_hit    (csr_hit),
    .i_csr_rdata  (csr_rdata),
    .i_a0         (a0),
    .o_retire_ok  (retire_ok),
    .o_take_intr  (take_intr),
    .o_rf_we      (rf_we),
    .o_rf_waddr   (rf_waddr),
    .o_rf_wdata   (rf_wdata),
    .o_commit     (o_commit),
    .o_trap       (o_trap),
    .o_trap_code  (o_trap_code),
    .o_cycle_cnt  (o_cycle_cnt),
    .o_instr_cnt  (o_instr_cnt)
  );

endmodule

`default_nettype wire

/* tests/retire_checker.sv */
/* concurrent checks bound into retire_top; every property is off while rst is high,
   so a reset after the trap is allowed to clear it */
`default_nettype none

module retire_checker (
  input wire        clk,
  input wire        rst,
  input wire        i_retire,
  input wire        commit_valid,
  input wire        trap,
  input wire [63:0] cycle_cnt,
  input wire [63:0] instr_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  a_valid_needs_retire: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> $past(i_retire))
    else begin
      fail_cnt++;
      $error("commit valid without a retire one cycle earlier");
    end

  a_trap_sticky: assert property (@(posedge clk) disable iff (rst)
    trap |=> trap)
    else begin
      fail_cnt++;
      $error("trap fell without reset");
    end

  a_counters_frozen: assert property (@(posedge clk) disable iff (rst)
    trap |=> ($stable(cycle_cnt) && $stable(instr_cnt)))
    else begin
      fail_cnt++;
      $error("counters moved after trap");
    end

endmodule

bind retire_top retire_checker chk0 (
  .clk          (clk),
  .rst          (rst),
  .i_retire     (i_retire),
  .commit_valid (o_commit.valid),
  .trap         (o_trap),
  .cycle_cnt    (o_cycle_cnt),
  .instr_cnt    (o_instr_cnt)
);

`default_nettype wire

/* tests/retire_monitor.sv */
/* reference model of the commit slice, updated on the rising edge and compared
   with the DUT outputs on the falling edge; payload is checked only while valid */
`default_nettype none

`include "commit_defs.svh"

module retire_monitor (
  input wire                     clk,
  input wire                     rst,
  input wire                     i_retire,
  input commit_pkg::retire_t     i_ret,
  input wire [31:0]              i_intr_no,
  input commit_pkg::commit_t     o_commit,
  input commit_pkg::csr_state_t  o_csr,
  input wire [63:0]              o_sstatus,
  input wire                     o_trap,
  input wire [2:0]               o_trap_code,
  input wire [63:0]              o_cycle_cnt,
  input wire [63:0]              o_instr_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  import commit_pkg::*;

  int          errors = 0;
  logic        primed = 1'b0;  // set by the first reset edge
  logic [63:0] m_regs [32];
  csr_state_t  m_csr;
  commit_t     m_cmt;
  logic        m_halt;
  logic [2:0]  m_code;
  logic [63:0] m_cyc;
  logic [63:0] m_ins;

  function automatic logic [63:0] csr_read(input csr_state_t c, input logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS:  return c.mstatus;
      `CSR_MIE:      return c.mie;
      `CSR_MTVEC:    return c.mtvec;
      `CSR_MSCRATCH: return c.mscratch;
      `CSR_MEPC:     return c.mepc;
      `CSR_MCAUSE:   return c.mcause;
      default:       return 64'd0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk) begin : model
    logic [31:0] w;
    logic        ok;
    logic        take;
    logic        hit;
    logic        wen;
    logic [63:0] src;
    logic [63:0] old;
    logic [63:0] nv;
    logic [63:0] wdata;
    w = i_ret.inst;
    if (rst) begin
      primed = 1'b1;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] = 64'd0;
      end
      m_csr = '0;
      m_cmt.valid = 1'b0;
      m_halt = 1'b0;
      m_code = 3'd0;
      m_cyc = 64'd0;
      m_ins = 64'd0;
    end else begin
      ok   = i_retire && (i_intr_no == 32'd0) && !m_halt;
      take = i_retire && (i_intr_no != 32'd0) && !m_halt;
      m_cmt.valid = ok;
      if (!m_halt) begin
        src   = m_regs[w[19:15]];
        hit   = ok && (w[6:0] == `SYSTEM_OPCODE) && (w[14:12] != 3'd0) && (w[14:12] <= 3'd3);
        old   = csr_read(m_csr, w[31:20]);
        wen   = i_ret.rd_wen || hit;
        wdata = hit ? old : i_ret.rd_wdata;
        case (w[14:12])
          3'd1:    nv = src;
          3'd2:    nv = old | src;
          default: nv = old & ~src;
        endcase
        m_cmt.pc    = i_ret.pc;
        m_cmt.inst  = i_ret.inst;
        m_cmt.wen   = wen;
        m_cmt.wdest = {3'd0, w[11:7]};
        m_cmt.wdata = wdata;
        m_cmt.skip  = i_ret.skip;
        m_cyc = m_cyc + 64'd1;
        if (ok) m_ins = m_ins + 64'd1;
        if (ok && w[6:0] == `TRAP_OPCODE) begin
          m_halt = 1'b1;
          m_code = m_regs[10][2:0];  // a0 before this retire
        end
        if (ok && wen && w[11:7] != 5'd0) m_regs[w[11:7]] = wdata;
        if (take) begin
          m_csr.mepc   = i_ret.pc;
          m_csr.mcause = (64'd1 << 63) | 64'(i_intr_no);  // interrupt flag in bit 63
        end else if (hit) begin
          case (w[31:20])
            `CSR_MSTATUS:  m_csr.mstatus  = nv;
            `CSR_MIE:      m_csr.mie      = nv;
            `CSR_MTVEC:    m_csr.mtvec    = nv;
            `CSR_MSCRATCH: m_csr.mscratch = nv;
            `CSR_MEPC:     m_csr.mepc     = nv;
            `CSR_MCAUSE:   m_csr.mcause   = nv;
            default: ;
          endcase
        end
      end
    end
  end

  always @(negedge clk) begin
    if (primed) begin
      check_val("o_commit.valid", 64'(m_cmt.valid), 64'(o_commit.valid));
      if (m_cmt.valid) begin
        check_val("o_commit.pc", m_cmt.pc, o_commit.pc);
        check_val("o_commit.inst", 64'(m_cmt.inst), 64'(o_commit.inst));
        check_val("o_commit.wen", 64'(m_cmt.wen), 64'(o_commit.wen));
        check_val("o_commit.wdest", 64'(m_cmt.wdest), 64'(o_commit.wdest));
        check_val("o_commit.wdata", m_cmt.wdata, o_commit.wdata);
        check_val("o_commit.skip", 64'(m_cmt.skip), 64'(o_commit.skip));
      end
      check_val("o_csr.mstatus", m_csr.mstatus, o_csr.mstatus);
      check_val("o_csr.mie", m_csr.mie, o_csr.mie);
      check_val("o_csr.mtvec", m_csr.mtvec, o_csr.mtvec);
      check_val("o_csr.mscratch", m_csr.mscratch, o_csr.mscratch);
      check_val("o_csr.mepc", m_csr.mepc, o_csr.mepc);
      check_val("o_csr.mcause", m_csr.mcause, o_csr.mcause);
      check_val("o_sstatus", m_csr.mstatus & `SSTATUS_MASK, o_sstatus);
      check_val("o_trap", 64'(m_halt), 64'(o_trap));
      check_val("o_trap_code", 64'(m_code), 64'(o_trap_code));
      check_val("o_cycle_cnt", m_cyc, o_cycle_cnt);
      check_val("o_instr_cnt", m_ins, o_instr_cnt);
    end
  end

endmodule

`default_nettype wire

/* tests/retire_tb.sv */
/* drives retire_top from a fixed table after a 16 cycle reset, then resets again after
   the trap; comparisons live in retire_monitor and the bound checker */
`default_nettype none

`include "commit_defs.svh"

module retire_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import commit_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int NROWS      = 20;

  typedef struct packed {
    logic        retire;
    retire_t     ret;
    logic [31:0] intr_no;
  } stim_row_t;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       i_retire = 1'b0;
  retire_t    i_ret = '0;
  logic [31:0] i_intr_no = 32'd0;
  commit_t    o_commit;
  csr_state_t o_csr;
  logic [63:0] o_sstatus;
  logic       o_trap;
  logic [2:0] o_trap_code;
  logic [63:0] o_cycle_cnt;
  logic [63:0] o_instr_cnt;
  integer     seed = 32'h5621;
  stim_row_t  stim [NROWS];
  int         total;

  retire_top dut0 (
    .clk(clk), .rst(rst), .i_retire(i_retire), .i_ret(i_ret), .i_intr_no(i_intr_no),
    .o_commit(o_commit), .o_csr(o_csr), .o_sstatus(o_sstatus), .o_trap(o_trap),
    .o_trap_code(o_trap_code), .o_cycle_cnt(o_cycle_cnt), .o_instr_cnt(o_instr_cnt)
  );

  retire_monitor mon0 (
    .clk(clk), .rst(rst), .i_retire(i_retire), .i_ret(i_ret), .i_intr_no(i_intr_no),
    .o_commit(o_commit), .o_csr(o_csr), .o_sstatus(o_sstatus), .o_trap(o_trap),
    .o_trap_code(o_trap_code), .o_cycle_cnt(o_cycle_cnt), .o_instr_cnt(o_instr_cnt)
  );

  function automatic logic [31:0] enc_alu(input logic [4:0] rd);
    return {7'd0, 5'd0, 5'd0, 3'd0, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] addr);
    return {addr, rs1, f3, rd, `SYSTEM_OPCODE};
  endfunction

  function automatic stim_row_t make_row(input logic rt, input logic [63:0] pc,
                                         input logic [31:0] inst, input logic wen,
                                         input logic [63:0] wdata, input logic [31:0] intr);
    stim_row_t r;
    r.retire       = rt;
    r.ret.pc       = pc;
    r.ret.inst     = inst;
    r.ret.rd_wen   = wen;
    r.ret.rd_wdata = wdata;
    r.ret.skip     = 1'b0;
    r.intr_no      = intr;
    return r;
  endfunction

  task automatic fill_table();
    stim[0]  = make_row(1, 64'h1000, enc_alu(5'd1), 1, 64'h1111, 0);
    stim[1]  = make_row(1, 64'h1004, enc_alu(5'd2), 1, {$random(seed), $random(seed)}, 0);
    stim[2]  = make_row(1, 64'h1008, enc_alu(5'd0), 1, 64'hdead, 0);  // x0 stays zero
    stim[3]  = make_row(1, 64'h100c, enc_csr(3'd1, 5'd3, 5'd1, `CSR_MSCRATCH), 0, 0, 0);
    stim[4]  = make_row(1, 64'h1010, enc_csr(3'd2, 5'd4, 5'd2, `CSR_MSCRATCH), 0, 0, 0);
    stim[5]  = make_row(1, 64'h1014, enc_csr(3'd3, 5'd5, 5'd1, `CSR_MSCRATCH), 0, 0, 0);
    stim[6]  = make_row(1, 64'h1018, enc_csr(3'd1, 5'd6, 5'd2, `CSR_MSTATUS), 0, 0, 0);
    stim[7]  = make_row(1, 64'h101c, enc_alu(5'd7), 1, 64'hffff_ffff_ffff_ffff, 0);
    stim[7].ret.skip = 1'b1;
    stim[8]  = make_row(1, 64'h1020, enc_csr(3'd2, 5'd8, 5'd7, `CSR_MSTATUS), 0, 0, 0);
    stim[9]  = make_row(0, 64'h0, 32'h0, 0, 0, 0);
    stim[10] = make_row(1, 64'h2000, enc_alu(5'd9), 1, 64'h99, 7);  // interrupt
    stim[11] = make_row(1, 64'h2004, enc_csr(3'd1, 5'd11, 5'd9, `CSR_MEPC), 0, 0, 0);  // x9 read
    stim[12] = make_row(1, 64'h2008, enc_csr(3'd2, 5'd12, 5'd0, `CSR_MCAUSE), 0, 0, 0);
    stim[13] = make_row(1, 64'h200c, enc_csr(3'd1, 5'd13, 5'd1, 12'h7c0), 0, 0, 0);
    stim[14] = make_row(0, 64'h0, 32'h0, 0, 0, 5);  // no strobe, no interrupt taken
    stim[15] = make_row(1, 64'h2010, enc_alu(5'd10), 1, {$random(seed), 32'h89ab_cd05}, 0);
    stim[16] = make_row(1, 64'h2014, {25'd0, `TRAP_OPCODE}, 0, 0, 0);
    stim[17] = make_row(1, 64'h2018, enc_alu(5'd1), 1, 64'h55, 0);  // after halt
    stim[18] = make_row(1, 64'h201c, enc_alu(5'd2), 1, 64'h66, 3);
    stim[19] = make_row(1, 64'h2020, enc_csr(3'd1, 5'd3, 5'd1, `CSR_MSCRATCH), 0, 0, 0);
  endtask

  task automatic apply_row(input stim_row_t r);
    i_retire  = r.retire;
    i_ret     = r.ret;
    i_intr_no = r.intr_no;
  endtask

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RST_CYCLES + NROWS + 40) * CLK_PERIOD);
    $display("timeout: the stimulus did not finish in the expected number of cycles");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    fill_table();
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    for (int n = 0; n < NROWS; n++) begin
      @(posedge clk);
      #2 apply_row(stim[n]);
    end
    @(posedge clk);
    #2 apply_row(make_row(0, 64'h0, 32'h0, 0, 0, 0));
    repeat (3) @(posedge clk);  // let the last record drain
    #2 rst = 1'b1;  // clears trap, counters and CSRs
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    repeat (2) @(posedge clk);
    #2 total = mon0.errors + dut0.chk0.fail_cnt;
    $display("errors: monitor %0d, assertions %0d", mon0.errors, dut0.chk0.fail_cnt);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/commit_pkg.sv
rtl/arch_regfile.sv
rtl/csr_file.sv
rtl/commit_unit.sv
rtl/retire_top.sv
tests/retire_checker.sv
tests/retire_monitor.sv
tests/retire_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := retire_tb
FLIST     := list.f
RUNFLAGS  := +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FLIST)) rtl/commit_defs.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
